// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pcie_status_monitor
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
pcie_link_pkg.sv
mon_regs_pkg.sv
fifo_rd_if.sv
link_change_detect.sv
error_classifier.sv
event_fifo.sv
wb_monitor_regs.sv
pcie_status_monitor.sv
tb_pcie_status_monitor.sv

// File: error_classifier.sv
module error_classifier (
    input  logic                           core_clk,
    input  logic                           core_rst_n,
    input  logic [mon_regs_pkg::N_ERR-1:0] err_flags,
    input  logic [mon_regs_pkg::N_ERR-1:0] expect_mask,
    output logic                           push,
    output mon_regs_pkg::err_event_t       event_rec,
    output logic [15:0]                    cnt_info,
    output logic [15:0]                    cnt_warn,
    output logic [15:0]                    cnt_err
);

    mon_regs_pkg::severity_t grade;
    logic [15:0]             cnt [3];

    // Highest severity among the set flags, expected ones count as info
    always_comb
    begin
        grade = mon_regs_pkg::SEV_INFO;
        for (int i = 0; i < mon_regs_pkg::N_ERR; i++)
        begin
            if (err_flags[i] && !expect_mask[i] &&
                (mon_regs_pkg::ERR_BASE_SEV[i] > grade))
                grade = mon_regs_pkg::ERR_BASE_SEV[i];
        end
    end

    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
            push <= 1'b0;
        else
            push <= |err_flags;
    end

    always_ff @(posedge core_clk)
    begin
        event_rec.grade <= grade;
        event_rec.flags <= err_flags;
    end

    // ------------------------------------------------------------
    // Saturating counters, one per grade
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
        begin
            for (int i = 0; i < 3; i++)
                cnt[i] <= 16'd0;
        end
        else if (push)
        begin
            for (int i = 0; i < 3; i++)
            begin
                if ((event_rec.grade == mon_regs_pkg::severity_t'(i)) && (cnt[i] != 16'hffff))
                    cnt[i] <= cnt[i] + 16'd1;
            end
        end
    end

    assign cnt_info = cnt[0];
    assign cnt_warn = cnt[1];
    assign cnt_err  = cnt[2];

endmodule

// File: event_fifo.sv
module event_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  logic     core_clk,
    input  logic     core_rst_n,
    input  logic     push,
    input  payload_t data,
    output logic     overflow,
    fifo_rd_if.fifo  rd
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full     = (32'(rd.level) == DEPTH);
    assign do_push  = push && !full;
    assign do_pop   = rd.pop && !rd.empty;
    // No back-pressure, a record into a full FIFO is lost
    assign overflow = push && full;

    assign rd.empty = (rd.level == '0);
    assign rd.head  = mem[rd_ptr];

    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd.level <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (32'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (32'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   rd.level <= rd.level + 1'b1;
                2'b01:   rd.level <= rd.level - 1'b1;
                default: rd.level <= rd.level;
            endcase
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= data;
    end

endmodule

// File: fifo_rd_if.sv
interface fifo_rd_if #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
);

    localparam int LW = $clog2(DEPTH + 1);

    logic          pop;
    logic          empty;
    payload_t      head;
    logic [LW-1:0] level;

    modport fifo (
        input  pop,
        output empty,
        output head,
        output level
    );

    modport reader (
        output pop,
        input  empty,
        input  head,
        input  level
    );

endinterface

// File: link_change_detect.sv
module link_change_detect (
    input  logic                        core_clk,
    input  logic                        core_rst_n,
    input  pcie_link_pkg::link_status_t status,
    output logic                        push,
    output mon_regs_pkg::link_event_t   event_rec
);

    pcie_link_pkg::link_status_t prev;
    logic [5:0]                  chg;
    logic                        unknown;

    // One bit per field
    assign chg = {
        status.pl_link_up  != prev.pl_link_up,
        status.dl_link_up  != prev.dl_link_up,
        status.link_speed  != prev.link_speed,
        status.link_width  != prev.link_width,
        status.ltssm_state != prev.ltssm_state,
        status.pm_state    != prev.pm_state
    };

    assign unknown = (status.ltssm_state > pcie_link_pkg::LTSSM_L2) ||
                     (status.pm_state > pcie_link_pkg::PM_STATE_MAX);

    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
        begin
            prev <= '{
                pl_link_up:  1'b0,
                dl_link_up:  1'b0,
                link_speed:  pcie_link_pkg::SPEED_2G5,
                link_width:  6'd0,
                ltssm_state: pcie_link_pkg::ltssm_state_t'(pcie_link_pkg::LTSSM_RESET_VAL),
                pm_state:    pcie_link_pkg::PM_IDLE
            };
            push <= 1'b0;
        end
        else
        begin
            prev <= status;
            push <= |chg;
        end
    end

    // Record built from the same sample as the compare
    always_ff @(posedge core_clk)
    begin
        event_rec.status        <= status;
        event_rec.change        <= chg;
        event_rec.unknown_state <= unknown;
    end

endmodule

// File: mon_regs_pkg.sv
package mon_regs_pkg;

    parameter int N_ERR = 16;
    parameter int WB_AW = 3;
    parameter int WB_DW = 32;

    typedef enum logic [1:0] {
        SEV_INFO    = 2'd0,
        SEV_WARNING = 2'd1,
        SEV_ERROR   = 2'd2
    } severity_t;

    // ------------------------------------------------------------
    // Base severity per error flag
    // ------------------------------------------------------------
    // 0..5   bad DLLP, bad TLP, replay timeout, replay rollover, NAK, phy error
    // 6..15  DL protocol, surprise down, poisoned TLP, FC protocol,
    //        completion timeout, completer abort, unexpected cpl,
    //        receiver overflow, ECRC, unsupported request
    parameter severity_t ERR_BASE_SEV [N_ERR] = '{
        SEV_WARNING, SEV_WARNING, SEV_WARNING, SEV_WARNING,
        SEV_WARNING, SEV_WARNING, SEV_ERROR,   SEV_ERROR,
        SEV_ERROR,   SEV_ERROR,   SEV_ERROR,   SEV_ERROR,
        SEV_ERROR,   SEV_ERROR,   SEV_ERROR,   SEV_ERROR
    };

    // Change mask follows link_status_t field order, pl_link_up in bit 5
    typedef struct packed {
        pcie_link_pkg::link_status_t status;
        logic [5:0]                  change;
        logic                        unknown_state;
    } link_event_t;

    typedef struct packed {
        severity_t        grade;
        logic [N_ERR-1:0] flags;
    } err_event_t;

    // Word addresses
    parameter logic [WB_AW-1:0] REG_STATUS   = 3'd0;
    parameter logic [WB_AW-1:0] REG_EXPECT   = 3'd1;
    parameter logic [WB_AW-1:0] REG_LINK_POP = 3'd2;
    parameter logic [WB_AW-1:0] REG_ERR_POP  = 3'd3;
    parameter logic [WB_AW-1:0] REG_CNT_INFO = 3'd4;
    parameter logic [WB_AW-1:0] REG_CNT_WARN = 3'd5;
    parameter logic [WB_AW-1:0] REG_CNT_ERR  = 3'd6;

endpackage

// File: pcie_link_pkg.sv
package pcie_link_pkg;

    // ------------------------------------------------------------
    // LTSSM and power management encodings
    // ------------------------------------------------------------
    typedef enum logic [5:0] {
        LTSSM_DETECT    = 6'd0,
        LTSSM_POLLING   = 6'd1,
        LTSSM_CFG       = 6'd2,
        LTSSM_L0        = 6'd3,
        LTSSM_REC       = 6'd4,
        LTSSM_DISABLE   = 6'd5,
        LTSSM_LOOPBACK  = 6'd6,
        LTSSM_HOT_RESET = 6'd7,
        LTSSM_TX_L0S    = 6'd8,
        LTSSM_L1        = 6'd9,
        LTSSM_L2        = 6'd10
    } ltssm_state_t;

    // Never a legal state, so leaving reset always logs a change
    parameter logic [5:0] LTSSM_RESET_VAL = 6'd63;

    typedef enum logic [4:0] {
        PM_IDLE           = 5'd0,
        PM_L1_WAIT_IDLE   = 5'd1,
        PM_L1_WAIT_REPLAY = 5'd2,
        PM_L1_READY       = 5'd3,
        PM_L1_STOP_DLLP   = 5'd4,
        PM_L1             = 5'd5,
        PM_L1_1           = 5'd6,
        PM_L1_2_ENTRY     = 5'd7,
        PM_L1_2_IDLE      = 5'd8,
        PM_L1_2_EXIT      = 5'd9,
        PM_L1_EXIT        = 5'd10,
        PM_L2_WAIT_IDLE   = 5'd11,
        PM_L2_WAIT_REPLAY = 5'd12,
        PM_L23_READY      = 5'd13,
        PM_L2_STOP_DLLP   = 5'd14,
        PM_L2             = 5'd15,
        PM_L0S            = 5'd16
    } pm_state_t;

    parameter logic [4:0] PM_STATE_MAX = 5'd16;

    typedef enum logic [1:0] {
        SPEED_2G5 = 2'd0,
        SPEED_5G  = 2'd1,
        SPEED_8G  = 2'd2
    } link_speed_t;

    typedef struct packed {
        logic         pl_link_up;
        logic         dl_link_up;
        link_speed_t  link_speed;
        logic [5:0]   link_width;
        ltssm_state_t ltssm_state;
        pm_state_t    pm_state;
    } link_status_t;

endpackage

// File: pcie_status_monitor.sv
module pcie_status_monitor #(
    parameter int LINK_FIFO_DEPTH = 8,
    parameter int ERR_FIFO_DEPTH  = 8
) (
    input  logic                           core_clk,
    input  logic                           core_rst_n,
    input  logic                           pl_link_up,
    input  logic                           dl_link_up,
    input  logic [1:0]                     link_speed,
    input  logic [5:0]                     link_width,
    input  logic [5:0]                     ltssm_state,
    input  logic [4:0]                     pm_state,
    input  logic [mon_regs_pkg::N_ERR-1:0] err_flags,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [mon_regs_pkg::WB_AW-1:0] wb_adr,
    input  logic [mon_regs_pkg::WB_DW-1:0] wb_dat_w,
    output logic [mon_regs_pkg::WB_DW-1:0] wb_dat_r,
    output logic                           wb_ack
);

    pcie_link_pkg::link_status_t    status;
    mon_regs_pkg::link_event_t      link_rec;
    mon_regs_pkg::err_event_t       err_rec;
    logic                           link_push;
    logic                           err_push;
    logic                           link_ovf;
    logic                           err_ovf;
    logic [mon_regs_pkg::N_ERR-1:0] expect_mask;
    logic [15:0]                    cnt_info;
    logic [15:0]                    cnt_warn;
    logic [15:0]                    cnt_err;

    // Raw codes may lie outside the enums, the detector flags them
    assign status.pl_link_up  = pl_link_up;
    assign status.dl_link_up  = dl_link_up;
    assign status.link_speed  = pcie_link_pkg::link_speed_t'(link_speed);
    assign status.link_width  = link_width;
    assign status.ltssm_state = pcie_link_pkg::ltssm_state_t'(ltssm_state);
    assign status.pm_state    = pcie_link_pkg::pm_state_t'(pm_state);

    fifo_rd_if #(.payload_t(mon_regs_pkg::link_event_t), .DEPTH(LINK_FIFO_DEPTH)) link_rd ();
    fifo_rd_if #(.payload_t(mon_regs_pkg::err_event_t), .DEPTH(ERR_FIFO_DEPTH)) err_rd ();

    link_change_detect i_link_detect (
        .core_clk   (core_clk),
        .core_rst_n (core_rst_n),
        .status     (status),
        .push       (link_push),
        .event_rec  (link_rec)
    );

    error_classifier i_err_class (
        .core_clk    (core_clk),
        .core_rst_n  (core_rst_n),
        .err_flags   (err_flags),
        .expect_mask (expect_mask),
        .push        (err_push),
        .event_rec   (err_rec),
        .cnt_info    (cnt_info),
        .cnt_warn    (cnt_warn),
        .cnt_err     (cnt_err)
    );

    event_fifo #(.payload_t(mon_regs_pkg::link_event_t), .DEPTH(LINK_FIFO_DEPTH)) i_link_fifo (
        .core_clk   (core_clk),
        .core_rst_n (core_rst_n),
        .push       (link_push),
        .data       (link_rec),
        .overflow   (link_ovf),
        .rd         (link_rd)
    );

    event_fifo #(.payload_t(mon_regs_pkg::err_event_t), .DEPTH(ERR_FIFO_DEPTH)) i_err_fifo (
        .core_clk   (core_clk),
        .core_rst_n (core_rst_n),
        .push       (err_push),
        .data       (err_rec),
        .overflow   (err_ovf),
        .rd         (err_rd)
    );

    wb_monitor_regs i_regs (
        .core_clk    (core_clk),
        .core_rst_n  (core_rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .link_rd     (link_rd),
        .err_rd      (err_rd),
        .link_ovf    (link_ovf),
        .err_ovf     (err_ovf),
        .cnt_info    (cnt_info),
        .cnt_warn    (cnt_warn),
        .cnt_err     (cnt_err),
        .expect_mask (expect_mask)
    );

endmodule

// File: tb_pcie_status_monitor.sv
module tb_pcie_status_monitor;

    localparam int LINK_DEPTH   = 8;
    localparam int ERR_DEPTH    = 8;
    localparam int LINK_ROUNDS  = 8;
    localparam int ERR_ROUNDS   = 6;
    localparam int ROUND_CYCLES = 64;
    // Reset and the reset check, every random round, the mask write and the overflow run
    localparam int CYCLE_LIMIT  = 300 + (LINK_ROUNDS + 2 * ERR_ROUNDS + 2) * ROUND_CYCLES;

    logic        core_clk = 1'b0;
    logic        core_rst_n;
    logic        pl_link_up;
    logic        dl_link_up;
    logic [1:0]  link_speed;
    logic [5:0]  link_width;
    logic [5:0]  ltssm_state;
    logic [4:0]  pm_state;
    logic [15:0] err_flags;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    // Model state
    logic [15:0] lfsr;
    logic [20:0] prev_status;
    logic [27:0] link_q [$];
    logic [17:0] err_q [$];
    logic [15:0] cnt_model [3];
    logic [15:0] mask_model;
    logic        link_ovf_model;
    logic        err_ovf_model;
    int          mismatch_count;
    int          other_count;
    int          cycle_count;

    pcie_status_monitor #(.LINK_FIFO_DEPTH(LINK_DEPTH), .ERR_FIFO_DEPTH(ERR_DEPTH)) i_dut (
        .core_clk    (core_clk),
        .core_rst_n  (core_rst_n),
        .pl_link_up  (pl_link_up),
        .dl_link_up  (dl_link_up),
        .link_speed  (link_speed),
        .link_width  (link_width),
        .ltssm_state (ltssm_state),
        .pm_state    (pm_state),
        .err_flags   (err_flags),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

    always #50 core_clk = ~core_clk;

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return r;
    endfunction

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Status layout {pl, dl, speed, width, ltssm, pm}
    function automatic void model_link(input logic [20:0] st);
        logic [5:0] chg;
        logic       unknown;
        chg[5]  = st[20] != prev_status[20];
        chg[4]  = st[19] != prev_status[19];
        chg[3]  = st[18:17] != prev_status[18:17];
        chg[2]  = st[16:11] != prev_status[16:11];
        chg[1]  = st[10:5] != prev_status[10:5];
        chg[0]  = st[4:0] != prev_status[4:0];
        unknown = (st[10:5] > 6'd10) || (st[4:0] > 5'd16);
        prev_status = st;
        if (chg != 6'd0)
        begin
            if (link_q.size() < LINK_DEPTH)
                link_q.push_back({st, chg, unknown});
            else
                link_ovf_model = 1'b1;
        end
    endfunction

    function automatic void model_err(input logic [15:0] flags);
        logic [1:0] grade;
        logic [1:0] sev;
        grade = 2'd0;
        for (int i = 0; i < 16; i++)
        begin
            if (flags[i])
            begin
                // Flags 0 to 5 are warnings, the rest errors, expected ones info
                sev = mask_model[i] ? 2'd0 : ((i < 6) ? 2'd1 : 2'd2);
                if (sev > grade)
                    grade = sev;
            end
        end
        if (flags != 16'd0)
        begin
            if (err_q.size() < ERR_DEPTH)
                err_q.push_back({grade, flags});
            else
                err_ovf_model = 1'b1;
            if (cnt_model[grade] != 16'hffff)
                cnt_model[grade] = cnt_model[grade] + 16'd1;
        end
    endfunction

    function automatic logic [20:0] next_status(input logic [20:0] cur);
        logic [20:0] st;
        st = cur;
        if (rand_bits(1) != 0)
            st[20] = ~st[20];
        if (rand_bits(1) != 0)
            st[19] = ~st[19];
        if (rand_bits(1) != 0)
            st[18:17] = 2'(rand_bits(2));
        if (rand_bits(1) != 0)
            st[16:11] = 6'(rand_bits(6));
        // Codes up to 15 reach past the last LTSSM state
        if (rand_bits(1) != 0)
            st[10:5] = 6'(rand_bits(4));
        if (rand_bits(1) != 0)
            st[4:0] = 5'(rand_bits(5));
        return st;
    endfunction

    // ------------------------------------------------------------
    // Bus and stimulus tasks
    // ------------------------------------------------------------
    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp)
        begin
            mismatch_count++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Ack is due in the cycle after the request edge
    task automatic wait_ack(input logic [2:0] adr);
        int cycles;
        cycles = 0;
        @(negedge core_clk);
        while (!wb_ack)
        begin
            cycles++;
            @(negedge core_clk);
        end
        if (cycles != 1)
        begin
            other_count++;
            $display("Ack for address %0d came after %0d cycles instead of one", adr, cycles);
        end
    endtask

    task automatic check_ack_low(input logic [2:0] adr);
        @(negedge core_clk);
        if (wb_ack)
        begin
            other_count++;
            $display("Ack for address %0d stayed high for more than one cycle", adr);
        end
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        @(posedge core_clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack(adr);
        data = wb_dat_r;
        @(posedge core_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        check_ack_low(adr);
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        @(posedge core_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack(adr);
        @(posedge core_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        check_ack_low(adr);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge core_clk);
    endtask

    task automatic apply_status(input logic [20:0] st);
        @(posedge core_clk);
        {pl_link_up, dl_link_up, link_speed, link_width, ltssm_state, pm_state} <= st;
        model_link(st);
    endtask

    task automatic drain_link(input string name);
        logic [31:0] d;
        logic [27:0] exp;
        while (link_q.size() > 0)
        begin
            exp = link_q.pop_front();
            wb_read(mon_regs_pkg::REG_LINK_POP, d);
            if (!d[31])
            begin
                other_count++;
                $display("%s: link FIFO read as empty while a record was expected", name);
            end
            else
                compare_word(name, {4'h8, exp}, d);
        end
        wb_read(mon_regs_pkg::REG_LINK_POP, d);
        compare_word({name, "_empty"}, 32'h0, d);
    endtask

    task automatic drain_err(input string name);
        logic [31:0] d;
        logic [17:0] exp;
        while (err_q.size() > 0)
        begin
            exp = err_q.pop_front();
            wb_read(mon_regs_pkg::REG_ERR_POP, d);
            if (!d[31])
            begin
                other_count++;
                $display("%s: error FIFO read as empty while a record was expected", name);
            end
            else
                compare_word(name, {1'b1, 13'd0, exp}, d);
        end
        wb_read(mon_regs_pkg::REG_ERR_POP, d);
        compare_word({name, "_empty"}, 32'h0, d);
    endtask

    task automatic check_counters(input string name);
        logic [31:0] d;
        wb_read(mon_regs_pkg::REG_CNT_INFO, d);
        compare_word({name, "_info"}, {16'h0, cnt_model[0]}, d);
        wb_read(mon_regs_pkg::REG_CNT_WARN, d);
        compare_word({name, "_warn"}, {16'h0, cnt_model[1]}, d);
        wb_read(mon_regs_pkg::REG_CNT_ERR, d);
        compare_word({name, "_err"}, {16'h0, cnt_model[2]}, d);
    endtask

    function automatic logic [31:0] expected_status();
        logic [31:0] s;
        s        = '0;
        s[0]     = link_ovf_model;
        s[1]     = err_ovf_model;
        s[11:8]  = 4'(link_q.size());
        s[19:16] = 4'(err_q.size());
        return s;
    endfunction

    task automatic link_round(input string name);
        int          n;
        logic [20:0] st;
        n  = 1 + int'(rand_bits(3) % 7);
        st = prev_status;
        repeat (n)
        begin
            st = next_status(st);
            apply_status(st);
        end
        idle(3);
        drain_link(name);
    endtask

    task automatic err_burst(input string name);
        int          n;
        logic [15:0] f;
        n = 1 + int'(rand_bits(3) % 7);
        repeat (n)
        begin
            f = 16'(rand_bits(16)) & 16'(rand_bits(16));
            // Some cycles with only warning flags
            if (rand_bits(1) != 0)
                f = f & 16'h003f;
            @(posedge core_clk);
            err_flags <= f;
            model_err(f);
        end
        @(posedge core_clk);
        err_flags <= 16'd0;
        idle(3);
        drain_err(name);
        check_counters(name);
    endtask

    task automatic overflow_run();
        logic [20:0] st;
        logic [31:0] d;
        wb_read(mon_regs_pkg::REG_STATUS, d);
        compare_word("ovf_status_before", expected_status(), d);
        st = prev_status;
        for (int k = 0; k < LINK_DEPTH + 3; k++)
        begin
            st     = next_status(st);
            st[19] = ~prev_status[19];
            apply_status(st);
        end
        idle(3);
        wb_read(mon_regs_pkg::REG_STATUS, d);
        compare_word("ovf_status", expected_status(), d);
        drain_link("ovf_records");
        wb_write(mon_regs_pkg::REG_STATUS, 32'h0);
        link_ovf_model = 1'b0;
        err_ovf_model  = 1'b0;
        wb_read(mon_regs_pkg::REG_STATUS, d);
        compare_word("ovf_cleared", expected_status(), d);
        wb_read(mon_regs_pkg::REG_ERR_POP, d);
        compare_word("ovf_err_empty", 32'h0, d);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin
        logic [31:0] d;
        logic [15:0] mask;
        core_rst_n     = 1'b0;
        pl_link_up     = 1'b0;
        dl_link_up     = 1'b0;
        link_speed     = 2'd0;
        link_width     = 6'd0;
        ltssm_state    = 6'd0;
        pm_state       = 5'd0;
        err_flags      = 16'd0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = 3'd0;
        wb_dat_w       = 32'd0;
        lfsr           = 16'd97;
        prev_status    = {1'b0, 1'b0, 2'd0, 6'd0, 6'd63, 5'd0};
        cnt_model[0]   = 16'd0;
        cnt_model[1]   = 16'd0;
        cnt_model[2]   = 16'd0;
        mask_model     = 16'd0;
        link_ovf_model = 1'b0;
        err_ovf_model  = 1'b0;
        mismatch_count = 0;
        other_count    = 0;

        repeat (3) @(posedge core_clk);
        core_rst_n <= 1'b1;
        // First sample after reset differs from the stored LTSSM state
        model_link({pl_link_up, dl_link_up, link_speed, link_width, ltssm_state, pm_state});
        idle(3);

        wb_read(mon_regs_pkg::REG_STATUS, d);
        compare_word("reset_status", expected_status(), d);
        drain_link("reset_link");
        check_counters("reset_cnt");

        repeat (LINK_ROUNDS) link_round("link_rand");
        repeat (ERR_ROUNDS) err_burst("err_rand");

        mask = 16'(rand_bits(16));
        wb_write(mon_regs_pkg::REG_EXPECT, {16'h0, mask});
        mask_model = mask;
        wb_read(mon_regs_pkg::REG_EXPECT, d);
        compare_word("expect_readback", {16'h0, mask_model}, d);
        repeat (ERR_ROUNDS) err_burst("expect_rand");

        overflow_run();

        $display("Errors: mismatch %0d, other %0d", mismatch_count, other_count);
        if (mismatch_count + other_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge core_clk);
            cycle_count++;
        end
        other_count++;
        $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
        $display("Errors: mismatch %0d, other %0d", mismatch_count, other_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: wb_monitor_regs.sv
module wb_monitor_regs (
    input  logic                           core_clk,
    input  logic                           core_rst_n,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [mon_regs_pkg::WB_AW-1:0] wb_adr,
    input  logic [mon_regs_pkg::WB_DW-1:0] wb_dat_w,
    output logic [mon_regs_pkg::WB_DW-1:0] wb_dat_r,
    output logic                           wb_ack,
    fifo_rd_if.reader                      link_rd,
    fifo_rd_if.reader                      err_rd,
    input  logic                           link_ovf,
    input  logic                           err_ovf,
    input  logic [15:0]                    cnt_info,
    input  logic [15:0]                    cnt_warn,
    input  logic [15:0]                    cnt_err,
    output logic [mon_regs_pkg::N_ERR-1:0] expect_mask
);

    logic                           req;
    logic                           wr_req;
    logic                           rd_req;
    logic                           link_ovf_sticky;
    logic                           err_ovf_sticky;
    logic [mon_regs_pkg::WB_DW-1:0] rd_data;

    // New cycle only while no ack is out
    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign wr_req = req && wb_we;
    assign rd_req = req && !wb_we;

    // Pop at the edge that captures the head
    assign link_rd.pop = rd_req && (wb_adr == mon_regs_pkg::REG_LINK_POP) && !link_rd.empty;
    assign err_rd.pop  = rd_req && (wb_adr == mon_regs_pkg::REG_ERR_POP) && !err_rd.empty;

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    // Status: bit 0 link overflow, bit 1 error overflow,
    // link level from bit 8, error level from bit 16
    always_comb
    begin
        rd_data = '0;
        case (wb_adr)
            mon_regs_pkg::REG_STATUS:
            begin
                rd_data[0]                         = link_ovf_sticky;
                rd_data[1]                         = err_ovf_sticky;
                rd_data[8 +: $bits(link_rd.level)] = link_rd.level;
                rd_data[16 +: $bits(err_rd.level)] = err_rd.level;
            end
            mon_regs_pkg::REG_EXPECT:
                rd_data[mon_regs_pkg::N_ERR-1:0] = expect_mask;
            mon_regs_pkg::REG_LINK_POP:
            begin
                if (!link_rd.empty)
                begin
                    rd_data[$bits(link_rd.head)-1:0] = link_rd.head;
                    rd_data[mon_regs_pkg::WB_DW-1]   = 1'b1;
                end
            end
            mon_regs_pkg::REG_ERR_POP:
            begin
                if (!err_rd.empty)
                begin
                    rd_data[$bits(err_rd.head)-1:0] = err_rd.head;
                    rd_data[mon_regs_pkg::WB_DW-1]  = 1'b1;
                end
            end
            mon_regs_pkg::REG_CNT_INFO: rd_data[15:0] = cnt_info;
            mon_regs_pkg::REG_CNT_WARN: rd_data[15:0] = cnt_warn;
            mon_regs_pkg::REG_CNT_ERR:  rd_data[15:0] = cnt_err;
            default:                    rd_data       = '0;
        endcase
    end

    always_ff @(posedge core_clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
        begin
            wb_ack          <= 1'b0;
            expect_mask     <= '0;
            link_ovf_sticky <= 1'b0;
            err_ovf_sticky  <= 1'b0;
        end
        else
        begin
            wb_ack <= req;
            if (wr_req && (wb_adr == mon_regs_pkg::REG_STATUS))
            begin
                link_ovf_sticky <= 1'b0;
                err_ovf_sticky  <= 1'b0;
            end
            // A new overflow beats a clear in the same cycle
            if (link_ovf)
                link_ovf_sticky <= 1'b1;
            if (err_ovf)
                err_ovf_sticky <= 1'b1;
            if (wr_req && (wb_adr == mon_regs_pkg::REG_EXPECT))
                expect_mask <= wb_dat_w[mon_regs_pkg::N_ERR-1:0];
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (rd_req)
            wb_dat_r <= rd_data;
    end

endmodule
